//--- common/core_pkg.sv
// shared widths and constants for the handheld core model
// bridge address map, video raster defaults, rom pacing
// and the fixed i2s ratios

package core_pkg;

    ////////////////////////////////////////////////////////////
    // bridge bus

    localparam int bridge_addr_w = 32;
    localparam int bridge_data_w = 32;

    // top address byte that routes writes to the rom loader
    localparam logic [7:0] rom_region = 8'h00;

    // bit 0 is the mouse toggle
    localparam logic [bridge_addr_w-1:0] settings_addr    = 32'h10000200;
    localparam logic [bridge_addr_w-1:0] frame_count_addr = 32'h10000204;

    ////////////////////////////////////////////////////////////
    // rom path

    // byte address into emulator memory
    localparam int rom_addr_w      = 16;
    // cycles between byte writes
    localparam int def_write_delay = 4;

    ////////////////////////////////////////////////////////////
    // video

    // r, g, b nibbles, red on top
    localparam int pixel_w = 12;
    localparam int rgb_w   = 24;
    localparam int coord_w = 10;

    localparam int def_h_bporch = 10;
    localparam int def_h_active = 256;
    localparam int def_h_total  = 1001;
    localparam int def_v_bporch = 10;
    localparam int def_v_active = 256;
    localparam int def_v_total  = 333;

    ////////////////////////////////////////////////////////////
    // audio

    // mclk cycles per bit clock
    localparam int sclk_div         = 4;
    // bit clocks per word-select half
    localparam int bits_per_channel = 32;

endpackage

//--- bridge/bridge_regs.sv
// bridge register block
// settings register with the mouse toggle bit,
// 16-bit frame counter, registered read mux

`timescale 1ns/1ps

module bridge_regs (
    input  logic                              audgen_mclk,
    input  logic                              reset_n,
    input  logic [core_pkg::bridge_addr_w-1:0] bridge_addr,
    input  logic                              bridge_wr,
    input  logic [core_pkg::bridge_data_w-1:0] bridge_wr_data,
    input  logic                              bridge_rd,
    // one pulse per frame from the video timer
    input  logic                              frame_tick,
    output logic [core_pkg::bridge_data_w-1:0] bridge_rd_data,
    output logic                              mouse_toggle
);

    import core_pkg::*;

    localparam int frame_cnt_w = 16;

    logic                   settings_sel;
    logic                   frame_cnt_sel;
    logic [frame_cnt_w-1:0] frame_count;

    // full 32-bit match, nothing aliased
    assign settings_sel  = (bridge_addr == settings_addr);
    assign frame_cnt_sel = (bridge_addr == frame_count_addr);

    ////////////////////////////////////////////////////////////
    // writes

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            mouse_toggle <= 1'b0;
        end else if (bridge_wr && settings_sel) begin
            // only bit 0 is kept
            mouse_toggle <= bridge_wr_data[0];
        end
    end

    // frame counter
    // free running, wraps at 16 bits
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            frame_count <= '0;
        end else if (frame_tick) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // reads

    // data lands the cycle after bridge_rd
    // and holds until the next read
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            bridge_rd_data <= '0;
        end else if (bridge_rd) begin
            if (settings_sel) begin
                bridge_rd_data <= bridge_data_w'(mouse_toggle);
            end else if (frame_cnt_sel) begin
                // zero extended
                bridge_rd_data <= bridge_data_w'(frame_count);
            end else begin
                // unmapped
                bridge_rd_data <= '0;
            end
        end
    end

endmodule

//--- bridge/rom_loader.sv
// rom loader
// latches a 32-bit bridge word aimed at the rom region and
// replays it as four paced byte writes, msb first

`timescale 1ns/1ps

module rom_loader #(
    // cycles between byte strobes, at least 2
    parameter int write_delay = core_pkg::def_write_delay
) (
    input  logic                              audgen_mclk,
    input  logic                              reset_n,
    input  logic [core_pkg::bridge_addr_w-1:0] bridge_addr,
    input  logic                              bridge_wr,
    input  logic [core_pkg::bridge_data_w-1:0] bridge_wr_data,
    output logic                              rom_wr,
    output logic [core_pkg::rom_addr_w-1:0]    rom_addr,
    output logic [7:0]                        rom_data
);

    import core_pkg::*;

    localparam int cnt_w = $clog2(write_delay + 1);

    logic                     busy;
    logic                     accept;
    logic                     fire;
    logic [cnt_w-1:0]         pace_cnt;
    logic [1:0]               byte_idx;
    logic [bridge_data_w-1:0] word_q;
    logic [rom_addr_w-1:0]    base_q;
    logic [7:0]               byte_sel;

    // writes landing while busy are dropped
    assign accept = bridge_wr && !busy
                  && (bridge_addr[bridge_addr_w-1 -: 8] == rom_region);

    // strobe registered on the next edge
    assign fire = busy && (pace_cnt == cnt_w'(write_delay - 1));

    // big-endian bridge, byte 0 is the top byte
    always_comb begin
        case (byte_idx)
            2'd0:    byte_sel = word_q[31:24];
            2'd1:    byte_sel = word_q[23:16];
            2'd2:    byte_sel = word_q[15:8];
            default: byte_sel = word_q[7:0];
        endcase
    end

    ////////////////////////////////////////////////////////////
    // control

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            busy     <= 1'b0;
            pace_cnt <= '0;
            byte_idx <= 2'd0;
            rom_wr   <= 1'b0;
        end else begin
            rom_wr <= 1'b0;
            if (accept) begin
                // accept cycle counts as zero
                busy     <= 1'b1;
                pace_cnt <= cnt_w'(1);
                byte_idx <= 2'd0;
            end else if (busy) begin
                pace_cnt <= pace_cnt + 1'b1;
                if (fire) begin
                    rom_wr   <= 1'b1;
                    pace_cnt <= '0;
                    byte_idx <= byte_idx + 2'd1;
                end
                // index wrapped back to 0 on the fourth strobe
                if (rom_wr && byte_idx == 2'd0) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // payload

    always_ff @(posedge audgen_mclk) begin
        if (accept) begin
            word_q <= bridge_wr_data;
            base_q <= bridge_addr[rom_addr_w-1:0];
        end
        if (fire) begin
            rom_data <= byte_sel;
            rom_addr <= base_q + rom_addr_w'(byte_idx);
        end
    end

endmodule

//--- video/video_timer.sv
// video timing generator
// raster counters, registered sync and data enable,
// 12-bit pixel expanded to 24-bit colour

`timescale 1ns/1ps

module video_timer #(
    parameter int h_bporch = core_pkg::def_h_bporch,
    parameter int h_active = core_pkg::def_h_active,
    parameter int h_total  = core_pkg::def_h_total,
    parameter int v_bporch = core_pkg::def_v_bporch,
    parameter int v_active = core_pkg::def_v_active,
    parameter int v_total  = core_pkg::def_v_total
) (
    input  logic                        audgen_mclk,
    input  logic                        reset_n,
    input  logic [core_pkg::pixel_w-1:0] pixel_rgb,
    output logic [core_pkg::rgb_w-1:0]   video_rgb,
    output logic                        video_de,
    output logic                        video_hs,
    output logic                        video_vs,
    output logic                        frame_tick
);

    import core_pkg::*;

    // raster limits at counter width
    localparam logic [coord_w-1:0] h_last     = coord_w'(h_total - 1);
    localparam logic [coord_w-1:0] v_last     = coord_w'(v_total - 1);
    localparam logic [coord_w-1:0] h_de_start = coord_w'(h_bporch);
    localparam logic [coord_w-1:0] h_de_end   = coord_w'(h_bporch + h_active);
    localparam logic [coord_w-1:0] v_de_start = coord_w'(v_bporch);
    localparam logic [coord_w-1:0] v_de_end   = coord_w'(v_bporch + v_active);
    // hs sits a few pixels after vs
    localparam logic [coord_w-1:0] hs_x       = coord_w'(3);

    logic [coord_w-1:0] x_count;
    logic [coord_w-1:0] y_count;
    logic               h_active_area;
    logic               v_active_area;
    logic [pixel_w-1:0] pixel_q;
    logic [rgb_w-1:0]   pixel_exp;

    assign h_active_area = (x_count >= h_de_start) && (x_count < h_de_end);
    assign v_active_area = (y_count >= v_de_start) && (y_count < v_de_end);

    // each nibble into the top of its byte, low nibble zero
    assign pixel_exp = {pixel_q[11:8], 4'h0, pixel_q[7:4], 4'h0, pixel_q[3:0], 4'h0};

    ////////////////////////////////////////////////////////////
    // raster counters

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else if (x_count == h_last) begin
            x_count <= '0;
            // end of line, step y
            if (y_count == v_last) begin
                y_count <= '0;
            end else begin
                y_count <= y_count + 1'b1;
            end
        end else begin
            x_count <= x_count + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // sync, enable, colour

    // outputs lag the counters by one cycle
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
            video_de  <= 1'b0;
            video_rgb <= '0;
        end else begin
            video_vs <= (x_count == '0) && (y_count == '0);
            video_hs <= (x_count == hs_x);
            video_de <= h_active_area && v_active_area;
            // black outside the active window
            if (h_active_area && v_active_area) begin
                video_rgb <= pixel_exp;
            end else begin
                video_rgb <= '0;
            end
        end
    end

    // single input stage for the emulator pixel
    always_ff @(posedge audgen_mclk) begin
        pixel_q <= pixel_rgb;
    end

    // frame start for the frame counter, same pulse as vs
    assign frame_tick = video_vs;

endmodule

//--- logic/i2s_silence.sv
// i2s silence generator
// bit clock from mclk divider, word select every
// 32 bit clocks, data line held low

`timescale 1ns/1ps

module i2s_silence (
    input  logic audgen_mclk,
    input  logic reset_n,
    output logic audio_sclk,
    output logic audio_lrck,
    output logic audio_dac
);

    import core_pkg::*;

    localparam int div_w = $clog2(sclk_div);
    localparam int bit_w = $clog2(bits_per_channel);

    logic [div_w-1:0] mclk_div;
    logic [bit_w-1:0] bit_cnt;
    logic             sclk_fall;

    // sclk is the divider msb with 4 mclk per bit
    assign audio_sclk = mclk_div[div_w-1];
    // divider about to wrap so sclk drops on this edge
    assign sclk_fall  = (mclk_div == div_w'(sclk_div - 1));

    // silent sample with every bit zero
    assign audio_dac = 1'b0;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            mclk_div   <= '0;
            bit_cnt    <= '0;
            audio_lrck <= 1'b0;
        end else begin
            mclk_div <= mclk_div + 1'b1;
            if (sclk_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
                // 32nd falling edge flips channel
                if (bit_cnt == bit_w'(bits_per_channel - 1)) begin
                    audio_lrck <= ~audio_lrck;
                end
            end
        end
    end

endmodule

//--- logic/pocket_core.sv
// user core top level
// bridge registers, rom loader, video timing and i2s silence
// all on the one audgen_mclk domain

`timescale 1ns/1ps

module pocket_core #(
    parameter int h_bporch    = core_pkg::def_h_bporch,
    parameter int h_active    = core_pkg::def_h_active,
    parameter int h_total     = core_pkg::def_h_total,
    parameter int v_bporch    = core_pkg::def_v_bporch,
    parameter int v_active    = core_pkg::def_v_active,
    parameter int v_total     = core_pkg::def_v_total,
    parameter int write_delay = core_pkg::def_write_delay
) (
    input  logic                              audgen_mclk,
    input  logic                              reset_n,
    // bridge bus from the host
    input  logic [core_pkg::bridge_addr_w-1:0] bridge_addr,
    input  logic                              bridge_wr,
    input  logic [core_pkg::bridge_data_w-1:0] bridge_wr_data,
    input  logic                              bridge_rd,
    output logic [core_pkg::bridge_data_w-1:0] bridge_rd_data,
    // byte writes toward emulator memory
    output logic                              rom_wr,
    output logic [core_pkg::rom_addr_w-1:0]    rom_addr,
    output logic [7:0]                        rom_data,
    output logic                              mouse_toggle,
    // emulator pixel in, scaler video out
    input  logic [core_pkg::pixel_w-1:0]       pixel_rgb,
    output logic [core_pkg::rgb_w-1:0]         video_rgb,
    output logic                              video_de,
    output logic                              video_hs,
    output logic                              video_vs,
    // i2s
    output logic                              audio_sclk,
    output logic                              audio_lrck,
    output logic                              audio_dac
);

    // start of frame, video timer to frame counter
    logic frame_tick;

    ////////////////////////////////////////////////////////////
    // host side

    bridge_regs bridge_regs_inst (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .frame_tick     (frame_tick),
        .bridge_rd_data (bridge_rd_data),
        .mouse_toggle   (mouse_toggle)
    );

    // rom loader snoops the same write bus
    rom_loader #(
        .write_delay (write_delay)
    ) rom_loader_inst (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .rom_wr         (rom_wr),
        .rom_addr       (rom_addr),
        .rom_data       (rom_data)
    );

    ////////////////////////////////////////////////////////////
    // video and audio

    video_timer #(
        .h_bporch (h_bporch),
        .h_active (h_active),
        .h_total  (h_total),
        .v_bporch (v_bporch),
        .v_active (v_active),
        .v_total  (v_total)
    ) video_timer_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pixel_rgb   (pixel_rgb),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .frame_tick  (frame_tick)
    );

    i2s_silence i2s_silence_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

endmodule

//--- sim/tb_clock_gen.sv
// testbench clock and reset source
// 4 ns audgen_mclk, reset_n low for 8 cycles

`timescale 1ns/1ps

module tb_clock_gen (
    output logic audgen_mclk,
    output logic reset_n
);

    // 250 MHz, half period 2 ns
    initial begin
        audgen_mclk = 1'b0;
        forever begin
            #2 audgen_mclk = ~audgen_mclk;
        end
    end

    // release on a falling edge, like every other input
    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge audgen_mclk);
        @(negedge audgen_mclk);
        reset_n = 1'b1;
    end

endmodule

//--- sim/tb_pocket_core.sv
// testbench for the handheld user core
// bridge register, rom loader, video raster and i2s checks
// small raster, lfsr stimulus, watchdog and result line

`timescale 1ns/1ps

module tb_pocket_core;

    import core_pkg::*;

    // shrunk raster so a frame is 120 cycles
    localparam int t_h_bporch    = 2;
    localparam int t_h_active    = 8;
    localparam int t_h_total     = 20;
    localparam int t_v_bporch    = 1;
    localparam int t_v_active    = 3;
    localparam int t_v_total     = 6;
    localparam int t_write_delay = 4;

    localparam int frame_cycles    = t_h_total * t_v_total;
    localparam int lrck_half       = sclk_div * bits_per_channel;
    localparam int bridge_cycles   = 100;
    localparam int watchdog_cycles = 8 + 4 * frame_cycles + bridge_cycles;
    localparam int clk_period_ns   = 4;

    localparam logic [31:0] lfsr_seed = 32'hdbe4835b;
    // x^32 + x^22 + x^2 + x + 1 in right shifting form
    localparam logic [31:0] lfsr_taps = 32'h80200003;

    logic                     audgen_mclk;
    logic                     reset_n;
    logic [bridge_addr_w-1:0] bridge_addr;
    logic                     bridge_wr;
    logic [bridge_data_w-1:0] bridge_wr_data;
    logic                     bridge_rd;
    logic [bridge_data_w-1:0] bridge_rd_data;
    logic                     rom_wr;
    logic [rom_addr_w-1:0]    rom_addr;
    logic [7:0]               rom_data;
    logic                     mouse_toggle;
    logic [pixel_w-1:0]       pixel_rgb;
    logic [rgb_w-1:0]         video_rgb;
    logic                     video_de;
    logic                     video_hs;
    logic                     video_vs;
    logic                     audio_sclk;
    logic                     audio_lrck;
    logic                     audio_dac;

    // bookkeeping
    int errors         = 0;
    int checks         = 0;
    int cyc            = 0;
    int post_reset     = 0;
    int vs_count       = 0;
    int de_count       = 0;
    int last_vs        = -1;
    int last_hs        = -1;
    int last_sclk      = -1;
    int last_lrck      = -1;
    int vs_gaps        = 0;
    int hs_gaps        = 0;
    int sclk_gaps      = 0;
    int lrck_gaps      = 0;
    int strobes_seen   = 0;
    int rom_busy_until = 0;
    int raster_pos     = 0;
    logic exp_de       = 1'b0;
    logic prev_sclk    = 1'b0;
    logic prev_lrck    = 1'b0;

    // pixel as sampled on the last two rising edges
    logic [pixel_w-1:0] pix_d1 = '0;
    logic [pixel_w-1:0] pix_d2 = '0;

    // separate lfsr states for pixels and bridge data
    logic [31:0] pix_state  = lfsr_seed;
    logic [31:0] data_state = lfsr_seed;

    // expected rom strobes with one entry per byte
    int                    exp_cyc[$];
    logic [rom_addr_w-1:0] exp_addr[$];
    logic [7:0]            exp_data[$];

    tb_clock_gen clock_gen_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n)
    );

    pocket_core #(
        .h_bporch    (t_h_bporch),
        .h_active    (t_h_active),
        .h_total     (t_h_total),
        .v_bporch    (t_v_bporch),
        .v_active    (t_v_active),
        .v_total     (t_v_total),
        .write_delay (t_write_delay)
    ) pocket_core_inst (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .rom_wr         (rom_wr),
        .rom_addr       (rom_addr),
        .rom_data       (rom_data),
        .mouse_toggle   (mouse_toggle),
        .pixel_rgb      (pixel_rgb),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs),
        .audio_sclk     (audio_sclk),
        .audio_lrck     (audio_lrck),
        .audio_dac      (audio_dac)
    );

    ////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ lfsr_taps;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, inout logic [31:0] state, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            bits  = {bits[30:0], state[0]};
        end
    endtask

    // each 4-bit channel goes to the top of its byte with a zero low nibble
    function automatic logic [rgb_w-1:0] expand_pixel(input logic [pixel_w-1:0] p);
        logic [rgb_w-1:0] c;
        c = '0;
        for (int ch = 0; ch < 3; ch++) begin
            c[8 * ch + 4 +: 4] = p[4 * ch +: 4];
        end
        return c;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("error: %s at %0t ns", msg, $time);
    endtask

    // called on a falling edge, returns on the next one
    task automatic write_bus(input logic [31:0] addr, input logic [31:0] data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge audgen_mclk);
        bridge_wr = 1'b0;
    endtask

    // registered read data is stable one falling edge later
    task automatic read_bus(input logic [31:0] addr, output logic [31:0] data);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(negedge audgen_mclk);
        bridge_rd = 1'b0;
        data      = bridge_rd_data;
    endtask

    ////////////////////////////////////////////////////////////
    // monitor samples outputs as registered before each edge

    always @(posedge audgen_mclk) begin
        cyc++;
        // in reset and the first edge out of it
        if (post_reset == 0) begin
            expect_equal("rom_wr", rom_wr, 0);
            expect_equal("video_de", video_de, 0);
            expect_equal("video_hs", video_hs, 0);
            expect_equal("video_vs", video_vs, 0);
            expect_equal("audio_lrck", audio_lrck, 0);
            expect_equal("audio_sclk", audio_sclk, 0);
            expect_equal("mouse_toggle", mouse_toggle, 0);
            expect_equal("bridge_rd_data", bridge_rd_data, 0);
        end
        if (reset_n) begin
            post_reset++;

            // frame start is also what the frame counter counts
            if (video_vs) begin
                if (last_vs >= 0) begin
                    expect_equal("video_vs spacing", cyc - last_vs, frame_cycles);
                    expect_equal("video_de count", de_count, t_h_active * t_v_active);
                    vs_gaps++;
                end
                last_vs  = cyc;
                de_count = 0;
                vs_count++;
            end
            if (video_de) begin
                de_count++;
            end
            if (video_hs) begin
                if (last_hs >= 0) begin
                    expect_equal("video_hs spacing", cyc - last_hs, t_h_total);
                    hs_gaps++;
                end
                last_hs = cyc;
            end

            // raster position counted from the last frame start
            if (last_vs >= 0) begin
                raster_pos = (cyc - last_vs) % frame_cycles;
                exp_de = ((raster_pos % t_h_total) >= t_h_bporch)
                      && ((raster_pos % t_h_total) < t_h_bporch + t_h_active)
                      && ((raster_pos / t_h_total) >= t_v_bporch)
                      && ((raster_pos / t_h_total) < t_v_bporch + t_v_active);
            end else begin
                exp_de = 1'b0;
            end
            expect_equal("video_de", video_de, exp_de);
            // colour lags the pixel input by two edges
            expect_equal("video_rgb", video_rgb, exp_de ? expand_pixel(pix_d2) : '0);

            // audio
            if (audio_sclk && !prev_sclk) begin
                if (last_sclk >= 0) begin
                    expect_equal("audio_sclk period", cyc - last_sclk, sclk_div);
                    sclk_gaps++;
                end
                last_sclk = cyc;
            end
            if (audio_lrck != prev_lrck) begin
                if (last_lrck >= 0) begin
                    expect_equal("audio_lrck spacing", cyc - last_lrck, lrck_half);
                    lrck_gaps++;
                end
                last_lrck = cyc;
            end
            expect_equal("audio_dac", audio_dac, 0);

            // rom strobes against the queue
            if (rom_wr) begin
                strobes_seen++;
                if (exp_cyc.size() == 0) begin
                    report_problem("rom_wr strobe with no rom write pending");
                end else begin
                    expect_equal("rom_wr cycle", cyc, exp_cyc.pop_front());
                    expect_equal("rom_addr", rom_addr, exp_addr.pop_front());
                    expect_equal("rom_data", rom_data, exp_data.pop_front());
                end
            end else if (exp_cyc.size() > 0 && cyc > exp_cyc[0]) begin
                report_problem("an expected rom_wr strobe never arrived");
                void'(exp_cyc.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end

            // accepted only when idle with bytes msb first
            if (bridge_wr && bridge_addr[31:24] == rom_region && cyc > rom_busy_until) begin
                for (int i = 0; i < 4; i++) begin
                    exp_cyc.push_back(cyc + t_write_delay * (i + 1));
                    exp_addr.push_back(bridge_addr[15:0] + 16'(i));
                    exp_data.push_back(bridge_wr_data[31 - 8 * i -: 8]);
                end
                // busy through the edge after the fourth strobe
                rom_busy_until = cyc + 4 * t_write_delay;
            end
        end
        prev_sclk = audio_sclk;
        prev_lrck = audio_lrck;
        pix_d2    = pix_d1;
        pix_d1    = pixel_rgb;
    end

    ////////////////////////////////////////////////////////////
    // stimulus

    // fresh random pixel every falling edge
    initial begin
        logic [31:0] bits;
        pixel_rgb = '0;
        forever begin
            @(negedge audgen_mclk);
            draw_bits(pixel_w, pix_state, bits);
            pixel_rgb = bits[pixel_w-1:0];
        end
    end

    initial begin
        logic [31:0] data;
        logic [31:0] frames_expected;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        bridge_rd      = 1'b0;
        @(posedge reset_n);
        repeat (2) @(negedge audgen_mclk);

        // settings register and unmapped read
        write_bus(settings_addr, 32'h0000_0001);
        expect_equal("mouse_toggle", mouse_toggle, 1);
        read_bus(settings_addr, data);
        expect_equal("bridge_rd_data", data, 1);
        read_bus(32'h1000_0208, data);
        expect_equal("bridge_rd_data", data, 0);
        // read data holds 1 again before the bit is cleared
        read_bus(settings_addr, data);
        expect_equal("bridge_rd_data", data, 1);
        write_bus(settings_addr, 32'hffff_fffe);
        expect_equal("mouse_toggle", mouse_toggle, 0);
        read_bus(settings_addr, data);
        expect_equal("bridge_rd_data", data, 0);

        // rom word and then one that lands while busy
        draw_bits(32, data_state, data);
        write_bus(32'h0000_1234, data);
        repeat (3) @(negedge audgen_mclk);
        draw_bits(32, data_state, data);
        write_bus(32'h0000_2000, data);
        while (exp_cyc.size() != 0) begin
            @(negedge audgen_mclk);
        end
        // first edge the loader is idle again
        draw_bits(32, data_state, data);
        write_bus(32'h0000_abc0, data);

        // frame counter vs frames seen so far
        while (vs_count < 2) begin
            @(negedge audgen_mclk);
        end
        frames_expected = vs_count;
        read_bus(frame_count_addr, data);
        expect_equal("bridge_rd_data", data, frames_expected);
        read_bus(32'h0000_0010, data);
        expect_equal("bridge_rd_data", data, 0);

        while (vs_count < 4) begin
            @(negedge audgen_mclk);
        end
        repeat (2) @(negedge audgen_mclk);

        // every check must have been reached
        if (exp_cyc.size() != 0) begin
            report_problem("rom strobes were still pending at the end of the run");
        end
        expect_equal("rom_wr count", strobes_seen, 8);
        if (vs_gaps < 2) begin
            report_problem("fewer than two full frames were checked");
        end
        if (hs_gaps == 0 || sclk_gaps == 0 || lrck_gaps == 0) begin
            report_problem("line or audio timing was never checked");
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // watchdog

    initial begin
        #(watchdog_cycles * clk_period_ns);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("checks %0d, errors %0d", checks, errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- pocket_core.f
common/core_pkg.sv
bridge/bridge_regs.sv
bridge/rom_loader.sv
video/video_timer.sv
logic/i2s_silence.sv
logic/pocket_core.sv
sim/tb_clock_gen.sv
sim/tb_pocket_core.sv

//--- Makefile
# Verilator build and run for the pocket_core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_pocket_core
FILELIST  := pocket_core.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
